/* common/rename_defines.svh */
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// architectural register file
`define NUM_REGS 32
`define REG_ID_W 5

// reorder buffer, depth must be a power of two
`define ROB_DEPTH 8
`define ROB_TAG_W 3

// data width
`define XLEN 32

`endif

/* common/rename_pkg.sv */
`include "rename_defines.svh"

package rename_pkg;

  // one instruction at dispatch
  typedef struct packed {
    logic [`REG_ID_W-1:0] rd;
    logic [`REG_ID_W-1:0] rs1;
    logic [`REG_ID_W-1:0] rs2;
  } disp_req_t;

  // resolved source, value valid only when ready
  typedef struct packed {
    logic                  ready;
    logic [`XLEN-1:0]      value;
    logic [`ROB_TAG_W-1:0] tag;
  } operand_t;

  typedef struct packed {
    logic [`ROB_TAG_W-1:0] tag;
    logic [`REG_ID_W-1:0]  rd;
    operand_t              op1;
    operand_t              op2;
  } issue_pkt_t;

  // result coming back from execution
  typedef struct packed {
    logic [`ROB_TAG_W-1:0] tag;
    logic [`XLEN-1:0]      value;
  } result_t;

  typedef struct packed {
    logic [`ROB_TAG_W-1:0] tag;
    logic [`REG_ID_W-1:0]  rd;
    logic [`XLEN-1:0]      value;
  } commit_t;

  // allocation sent to the register file
  typedef struct packed {
    logic [`REG_ID_W-1:0]  rd;
    logic [`ROB_TAG_W-1:0] tag;
  } rename_t;

  // register file answer for one source
  typedef struct packed {
    logic                  busy;
    logic [`ROB_TAG_W-1:0] tag;
    logic [`XLEN-1:0]      value;
  } lookup_t;

endpackage

/* regfile/reg_file.sv */
`include "rename_defines.svh"

module reg_file (
  input  logic                   clk_in,
  input  logic                   rst_in,
  input  logic                   flush,
  // operand lookup
  input  logic [`REG_ID_W-1:0]   rs1,
  input  logic [`REG_ID_W-1:0]   rs2,
  output rename_pkg::lookup_t    look1,
  output rename_pkg::lookup_t    look2,
  // rename from dispatch
  input  logic                   alloc,
  input  rename_pkg::rename_t    alloc_info,
  // retirement from the reorder buffer
  input  logic                   commit_valid,
  input  rename_pkg::commit_t    commit
);

  logic [`XLEN-1:0]      regs_q [`NUM_REGS];
  logic [`ROB_TAG_W-1:0] tag_q  [`NUM_REGS];
  logic [`NUM_REGS-1:0]  busy_q;

  logic commit_wr;
  logic rename_wr;
  logic commit_clear;

  // x0 is never written and never renamed
  assign commit_wr = commit_valid && (commit.rd != '0);
  assign rename_wr = alloc && (alloc_info.rd != '0);

  // only the latest producer releases the busy mark,
  // and a rename of the same register this cycle takes priority
  assign commit_clear = commit_wr &&
                        (tag_q[commit.rd] == commit.tag) &&
                        !(rename_wr && (alloc_info.rd == commit.rd));

  // lookups come from stored state only
  always_comb begin
    look1.busy  = busy_q[rs1];
    look1.tag   = tag_q[rs1];
    look1.value = regs_q[rs1];
    look2.busy  = busy_q[rs2];
    look2.tag   = tag_q[rs2];
    look2.value = regs_q[rs2];
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs_q[i] <= '0;
        tag_q[i]  <= '0;
      end
      busy_q <= '0;
    end else begin
      // a retired result is architectural, even during flush
      if (commit_wr) begin
        regs_q[commit.rd] <= commit.value;
      end

      if (flush) begin
        busy_q <= '0;
      end else begin
        if (commit_clear) begin
          busy_q[commit.rd] <= 1'b0;
        end
        if (rename_wr) begin
          busy_q[alloc_info.rd] <= 1'b1;
          tag_q[alloc_info.rd]  <= alloc_info.tag;
        end
      end
    end
  end

endmodule

/* rob/reorder_buffer.sv */
`include "rename_defines.svh"

module reorder_buffer (
  input  logic                   clk_in,
  input  logic                   rst_in,
  input  logic                   flush,
  // allocation
  input  logic                   alloc,
  input  rename_pkg::rename_t    alloc_info,
  output logic [`ROB_TAG_W-1:0]  alloc_tag,
  output logic                   full,
  // results from execution
  input  logic                   result_valid,
  input  rename_pkg::result_t    result,
  // operand forwarding
  input  logic [`ROB_TAG_W-1:0]  query_tag1,
  input  logic [`ROB_TAG_W-1:0]  query_tag2,
  output logic                   ready1,
  output logic                   ready2,
  output logic [`XLEN-1:0]       val1,
  output logic [`XLEN-1:0]       val2,
  // retirement
  output logic                   commit_valid,
  output rename_pkg::commit_t    commit
);

  logic [`ROB_DEPTH-1:0]  valid_q;
  logic [`ROB_DEPTH-1:0]  done_q;
  logic [`REG_ID_W-1:0]   rd_q    [`ROB_DEPTH];
  logic [`XLEN-1:0]       value_q [`ROB_DEPTH];

  logic [`ROB_TAG_W-1:0]  head_q;
  logic [`ROB_TAG_W-1:0]  tail_q;
  logic [`ROB_TAG_W:0]    count_q;

  logic retire;
  logic capture;

  assign alloc_tag = tail_q;
  assign full      = (count_q == `ROB_DEPTH);

  assign retire  = valid_q[head_q] && done_q[head_q] && !flush;
  assign capture = result_valid && valid_q[result.tag] && !done_q[result.tag];

  // a done entry answers directly, a just retired one from the commit register
  function automatic logic [`XLEN:0] forward(input logic [`ROB_TAG_W-1:0] tag);
    logic [`XLEN:0] ans;
    ans = '0;
    if (valid_q[tag] && done_q[tag]) begin
      ans = {1'b1, value_q[tag]};
    end else if (commit_valid && (commit.tag == tag)) begin
      ans = {1'b1, commit.value};
    end
    return ans;
  endfunction

  assign {ready1, val1} = forward(query_tag1);
  assign {ready2, val2} = forward(query_tag2);

  always_ff @(posedge clk_in) begin
    if (rst_in || flush) begin
      valid_q      <= '0;
      done_q       <= '0;
      head_q       <= '0;
      tail_q       <= '0;
      count_q      <= '0;
      commit_valid <= 1'b0;
    end else begin
      if (alloc) begin
        valid_q[alloc_info.tag] <= 1'b1;
        done_q[alloc_info.tag]  <= 1'b0;
        tail_q                  <= tail_q + 1'b1;
      end
      // results for empty or finished entries are dropped
      if (capture) begin
        done_q[result.tag] <= 1'b1;
      end
      if (retire) begin
        valid_q[head_q] <= 1'b0;
        head_q          <= head_q + 1'b1;
      end
      count_q      <= count_q + (`ROB_TAG_W+1)'(alloc) - (`ROB_TAG_W+1)'(retire);
      commit_valid <= retire;
    end
  end

  // payload
  always_ff @(posedge clk_in) begin
    if (alloc) begin
      rd_q[alloc_info.tag] <= alloc_info.rd;
    end
    if (capture) begin
      value_q[result.tag] <= result.value;
    end
    if (retire) begin
      commit.tag   <= head_q;
      commit.rd    <= rd_q[head_q];
      commit.value <= value_q[head_q];
    end
  end

endmodule

/* logic/dispatch_ctrl.sv */
`include "rename_defines.svh"

module dispatch_ctrl (
  input  logic                   clk_in,
  input  logic                   rst_in,
  input  logic                   flush,
  // dispatch handshake
  input  logic                   disp_valid,
  input  rename_pkg::disp_req_t  disp_req,
  output logic                   disp_ready,
  // issue handshake
  output logic                   issue_valid,
  output rename_pkg::issue_pkt_t issue_pkt,
  input  logic                   issue_ready,
  // datapath status
  input  logic                   rob_full,
  input  logic [`ROB_TAG_W-1:0]  alloc_tag,
  input  rename_pkg::lookup_t    rf_look1,
  input  rename_pkg::lookup_t    rf_look2,
  input  logic                   rob_ready1,
  input  logic                   rob_ready2,
  input  logic [`XLEN-1:0]       rob_val1,
  input  logic [`XLEN-1:0]       rob_val2,
  output logic                   alloc,
  output rename_pkg::rename_t    alloc_info
);

  logic started_q;
  logic accept;

  // committed value, then forwarded value, else wait on the producer tag
  function automatic rename_pkg::operand_t resolve(input rename_pkg::lookup_t look,
                                                   input logic fwd_ready,
                                                   input logic [`XLEN-1:0] fwd_val);
    rename_pkg::operand_t op;
    op = '0;
    if (!look.busy) begin
      op.ready = 1'b1;
      op.value = look.value;
    end else if (fwd_ready) begin
      op.ready = 1'b1;
      op.value = fwd_val;
    end else begin
      op.tag = look.tag;
    end
    return op;
  endfunction

  assign disp_ready = started_q && !rob_full && !flush && !(issue_valid && !issue_ready);
  assign accept     = disp_valid && disp_ready;

  assign alloc          = accept;
  assign alloc_info.rd  = disp_req.rd;
  assign alloc_info.tag = alloc_tag;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      started_q   <= 1'b0;
      issue_valid <= 1'b0;
    end else begin
      started_q <= 1'b1;
      if (flush) begin
        issue_valid <= 1'b0;
      end else if (accept) begin
        issue_valid <= 1'b1;
      end else if (issue_ready) begin
        issue_valid <= 1'b0;
      end
    end
  end

  // snapshot taken once at acceptance, held under back-pressure
  always_ff @(posedge clk_in) begin
    if (accept) begin
      issue_pkt.tag <= alloc_tag;
      issue_pkt.rd  <= disp_req.rd;
      issue_pkt.op1 <= resolve(rf_look1, rob_ready1, rob_val1);
      issue_pkt.op2 <= resolve(rf_look2, rob_ready2, rob_val2);
    end
  end

endmodule

/* logic/rename_core_top.sv */
`include "rename_defines.svh"

module rename_core_top (
  input  logic                   clk_in,
  input  logic                   rst_in,
  input  logic                   flush,
  input  logic                   disp_valid,
  input  rename_pkg::disp_req_t  disp_req,
  output logic                   disp_ready,
  output logic                   issue_valid,
  output rename_pkg::issue_pkt_t issue_pkt,
  input  logic                   issue_ready,
  input  logic                   result_valid,
  input  rename_pkg::result_t    result,
  output logic                   commit_valid,
  output rename_pkg::commit_t    commit
);

  logic                  rob_full;
  logic [`ROB_TAG_W-1:0] alloc_tag;
  rename_pkg::lookup_t   rf_look1;
  rename_pkg::lookup_t   rf_look2;
  logic                  rob_ready1;
  logic                  rob_ready2;
  logic [`XLEN-1:0]      rob_val1;
  logic [`XLEN-1:0]      rob_val2;
  logic                  alloc;
  rename_pkg::rename_t   alloc_info;

  dispatch_ctrl u_dispatch_ctrl (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .flush       (flush),
    .disp_valid  (disp_valid),
    .disp_req    (disp_req),
    .disp_ready  (disp_ready),
    .issue_valid (issue_valid),
    .issue_pkt   (issue_pkt),
    .issue_ready (issue_ready),
    .rob_full    (rob_full),
    .alloc_tag   (alloc_tag),
    .rf_look1    (rf_look1),
    .rf_look2    (rf_look2),
    .rob_ready1  (rob_ready1),
    .rob_ready2  (rob_ready2),
    .rob_val1    (rob_val1),
    .rob_val2    (rob_val2),
    .alloc       (alloc),
    .alloc_info  (alloc_info)
  );

  reg_file u_reg_file (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .flush        (flush),
    .rs1          (disp_req.rs1),
    .rs2          (disp_req.rs2),
    .look1        (rf_look1),
    .look2        (rf_look2),
    .alloc        (alloc),
    .alloc_info   (alloc_info),
    .commit_valid (commit_valid),
    .commit       (commit)
  );

  // forwarding queries use the producer tags from the register file
  reorder_buffer u_reorder_buffer (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .flush        (flush),
    .alloc        (alloc),
    .alloc_info   (alloc_info),
    .alloc_tag    (alloc_tag),
    .full         (rob_full),
    .result_valid (result_valid),
    .result       (result),
    .query_tag1   (rf_look1.tag),
    .query_tag2   (rf_look2.tag),
    .ready1       (rob_ready1),
    .ready2       (rob_ready2),
    .val1         (rob_val1),
    .val2         (rob_val2),
    .commit_valid (commit_valid),
    .commit       (commit)
  );

endmodule

/* verif/rename_core_chk.sv */
`include "rename_defines.svh"

module rename_core_chk (
  input logic                  clk_in,
  input logic                  rst_in,
  input logic [`ROB_TAG_W:0]   count_q,
  input logic                  commit_valid,
  input logic                  full,
  input logic                  alloc
);
  timeunit 1ns;
  timeprecision 1ps;

  count_bound: assert property (@(posedge clk_in) disable iff (rst_in)
    count_q <= (`ROB_TAG_W+1)'(`ROB_DEPTH))
    else $error("reorder buffer count above its depth");

  // a commit needs an entry in the buffer on the edge before
  commit_not_empty: assert property (@(posedge clk_in) disable iff (rst_in)
    commit_valid |-> $past(count_q) != '0)
    else $error("commit from an empty reorder buffer");

  full_no_alloc: assert property (@(posedge clk_in) disable iff (rst_in)
    full |-> !alloc)
    else $error("allocation while reorder buffer full");

endmodule

bind reorder_buffer rename_core_chk u_rename_core_chk (
  .clk_in       (clk_in),
  .rst_in       (rst_in),
  .count_q      (count_q),
  .commit_valid (commit_valid),
  .full         (full),
  .alloc        (alloc)
);

/* verif/rename_core_tb.sv */
`include "rename_defines.svh"

module rename_core_tb;
  timeunit 1ns;
  timeprecision 1ps;

  // model entry for one in-flight instruction
  typedef struct packed {
    logic [`ROB_TAG_W-1:0] tag;
    logic [`REG_ID_W-1:0]  rd;
    logic                  done;
    logic [`XLEN-1:0]      value;
  } entry_t;

  logic                   clk_in;
  logic                   rst_in;
  logic                   flush;
  logic                   disp_valid;
  rename_pkg::disp_req_t  disp_req;
  logic                   disp_ready;
  logic                   issue_valid;
  rename_pkg::issue_pkt_t issue_pkt;
  logic                   issue_ready;
  logic                   result_valid;
  rename_pkg::result_t    result;
  logic                   commit_valid;
  rename_pkg::commit_t    commit;

  logic [`XLEN-1:0]       arch [`NUM_REGS];
  entry_t                 inflight [$];
  rename_pkg::issue_pkt_t exp_issue [$];
  logic [`ROB_TAG_W-1:0]  tail;
  logic                   last_accept;
  logic                   saw_full;
  int                     errors;
  int                     test_errors;
  int                     tests;

  rename_core_top u_rename_core_top (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .flush        (flush),
    .disp_valid   (disp_valid),
    .disp_req     (disp_req),
    .disp_ready   (disp_ready),
    .issue_valid  (issue_valid),
    .issue_pkt    (issue_pkt),
    .issue_ready  (issue_ready),
    .result_valid (result_valid),
    .result       (result),
    .commit_valid (commit_valid),
    .commit       (commit)
  );

  initial begin
    clk_in = 1'b0;
    forever #4 clk_in = ~clk_in;
  end

  // youngest older writer decides, a result counts only from an earlier cycle
  function automatic rename_pkg::operand_t expect_operand(input logic [`REG_ID_W-1:0] rs);
    rename_pkg::operand_t op;
    op = '0;
    op.ready = 1'b1;
    op.value = arch[rs];
    if (rs != '0) begin
      for (int i = inflight.size() - 1; i >= 0; i--) begin
        if (inflight[i].rd == rs) begin
          op.ready = inflight[i].done;
          op.value = inflight[i].done ? inflight[i].value : '0;
          op.tag   = inflight[i].done ? '0 : inflight[i].tag;
          break;
        end
      end
    end
    return op;
  endfunction

  function automatic rename_pkg::issue_pkt_t expect_issue(input rename_pkg::disp_req_t req,
                                                          input logic [`ROB_TAG_W-1:0] tag);
    rename_pkg::issue_pkt_t pkt;
    pkt.tag = tag;
    pkt.rd  = req.rd;
    pkt.op1 = expect_operand(req.rs1);
    pkt.op2 = expect_operand(req.rs2);
    return pkt;
  endfunction

  task automatic report_error(input string msg);
    $display("ERROR at %0d ns: %s", $time, msg);
    test_errors++;
  endtask

  task automatic check_issue(input rename_pkg::issue_pkt_t got, input rename_pkg::issue_pkt_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0d ns: issue packet %h, expected %h", $time, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_commit(input rename_pkg::commit_t got, input rename_pkg::commit_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0d ns: commit %h, expected %h", $time, got, exp);
      test_errors++;
    end
  endtask

  // compare and advance the model with the values seen at this edge
  task automatic step();
    rename_pkg::commit_t exp_c;
    entry_t              e;
    logic                accept;
    logic                stalled;
    int                  rob_count;
    accept  = disp_valid && disp_ready;
    stalled = issue_valid && !issue_ready;
    // the entry retired on the last edge stays in the model until its commit is seen
    rob_count = inflight.size() - int'(commit_valid);
    if (rob_count == `ROB_DEPTH) saw_full = 1'b1;
    if (last_accept && !issue_valid) report_error("no issue packet one cycle after dispatch");
    if (stalled && disp_ready) report_error("dispatch open while issue stalled");
    if (disp_ready && rob_count == `ROB_DEPTH) begin
      report_error("dispatch open while reorder buffer full");
    end
    if (!disp_ready && !flush && !stalled && rob_count < `ROB_DEPTH) begin
      report_error("dispatch held off with room in the reorder buffer");
    end
    if (issue_valid) begin
      if (exp_issue.size() == 0) begin
        report_error("issue packet with no dispatched instruction");
      end else begin
        check_issue(issue_pkt, exp_issue[0]);
        if (issue_ready) void'(exp_issue.pop_front());
      end
    end
    if (commit_valid) begin
      if (inflight.size() == 0 || !inflight[0].done) begin
        report_error("commit with no finished instruction at the head");
      end else begin
        exp_c = '{tag: inflight[0].tag, rd: inflight[0].rd, value: inflight[0].value};
        check_commit(commit, exp_c);
        if (exp_c.rd != '0) arch[exp_c.rd] = exp_c.value;
        void'(inflight.pop_front());
      end
    end
    // lookup happens before this edge's result and allocation
    if (accept) begin
      exp_issue.push_back(expect_issue(disp_req, tail));
      e = '{tag: tail, rd: disp_req.rd, done: 1'b0, value: '0};
    end
    if (result_valid) begin
      foreach (inflight[i]) begin
        if (inflight[i].tag == result.tag && !inflight[i].done) begin
          inflight[i].done  = 1'b1;
          inflight[i].value = result.value;
        end
      end
    end
    if (accept) begin
      inflight.push_back(e);
      tail = tail + 1'b1;
    end
    if (flush) begin
      inflight.delete();
      exp_issue.delete();
      tail = '0;
    end
    last_accept = accept;
  endtask

  task automatic drive(input int unsigned p_disp, input int unsigned p_ready,
                       input int unsigned p_res, input int unsigned rd_lo,
                       input int unsigned rd_hi, input int unsigned rs_lo,
                       input int unsigned rs_hi);
    int                    pend [$];
    int                    pick;
    rename_pkg::disp_req_t req;
    rename_pkg::result_t   res;
    foreach (inflight[i]) begin
      if (!inflight[i].done) pend.push_back(i);
    end
    req.rd  = `REG_ID_W'($urandom_range(rd_hi, rd_lo));
    req.rs1 = `REG_ID_W'($urandom_range(rs_hi, rs_lo));
    req.rs2 = `REG_ID_W'($urandom_range(rs_hi, rs_lo));
    disp_valid   <= ($urandom_range(99, 0) < p_disp);
    disp_req     <= req;
    issue_ready  <= ($urandom_range(99, 0) < p_ready);
    result_valid <= 1'b0;
    // results go back in random order
    if (pend.size() != 0 && $urandom_range(99, 0) < p_res) begin
      pick = pend[$urandom_range(pend.size() - 1, 0)];
      res.tag   = inflight[pick].tag;
      res.value = $urandom();
      result_valid <= 1'b1;
      result       <= res;
    end
  endtask

  task automatic run_cycles(input int cycles, input int unsigned p_disp,
                            input int unsigned p_ready, input int unsigned p_res,
                            input int unsigned rd_lo, input int unsigned rd_hi,
                            input int unsigned rs_lo, input int unsigned rs_hi);
    repeat (cycles) begin
      @(posedge clk_in);
      step();
      drive(p_disp, p_ready, p_res, rd_lo, rd_hi, rs_lo, rs_hi);
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while ((inflight.size() != 0 || exp_issue.size() != 0) && waited < 300) begin
      @(posedge clk_in);
      step();
      drive(0, 100, 60, 1, 31, 0, 31);
      waited++;
    end
    if (inflight.size() != 0 || exp_issue.size() != 0) begin
      report_error("timeout while waiting for in-flight instructions to retire");
    end
  endtask

  task automatic finish_test(input string name);
    tests++;
    errors += test_errors;
    $display("test %-16s %s", name, (test_errors == 0) ? "ok" : "with errors");
    test_errors = 0;
  endtask

  initial begin
    int waited;
    void'($urandom(69));
    rst_in       = 1'b1;
    flush        = 1'b0;
    disp_valid   = 1'b0;
    disp_req     = '0;
    issue_ready  = 1'b0;
    result_valid = 1'b0;
    result       = '0;
    foreach (arch[i]) arch[i] = '0;
    tail        = '0;
    last_accept = 1'b0;
    saw_full    = 1'b0;
    errors      = 0;
    test_errors = 0;
    tests       = 0;
    repeat (16) @(posedge clk_in);
    rst_in <= 1'b0;
    waited = 0;
    while (!disp_ready && waited < 20) begin
      @(posedge clk_in);
      waited++;
    end
    if (!disp_ready) report_error("dispatch never became ready after reset");
    errors += test_errors;
    test_errors = 0;

    // several writers per register, results out of order
    run_cycles(150, 70, 80, 50, 1, 15, 0, 15);
    drain();
    finish_test("in_order_commit");

    // sources never written by anything in flight
    run_cycles(80, 60, 100, 60, 16, 31, 0, 15);
    drain();
    finish_test("independent");

    // short chains over a few registers
    run_cycles(150, 80, 90, 40, 1, 3, 0, 3);
    drain();
    finish_test("dependencies");

    // no results, issue stalls first, then the buffer fills up
    saw_full = 1'b0;
    run_cycles(20, 100, 20, 0, 1, 7, 0, 7);
    run_cycles(20, 100, 100, 0, 1, 7, 0, 7);
    if (!saw_full) report_error("reorder buffer never filled up");
    drain();
    finish_test("back_pressure");

    run_cycles(30, 80, 70, 30, 1, 7, 0, 7);
    @(posedge clk_in);
    step();
    flush        <= 1'b1;
    disp_valid   <= 1'b0;
    result_valid <= 1'b0;
    issue_ready  <= 1'b1;
    @(posedge clk_in);
    step();
    flush <= 1'b0;
    run_cycles(40, 70, 90, 50, 1, 7, 0, 7);
    drain();
    finish_test("flush");

    $display("tests run %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* list.f */
+incdir+common
common/rename_pkg.sv
regfile/reg_file.sv
rob/reorder_buffer.sv
logic/dispatch_ctrl.sv
logic/rename_core_top.sv
verif/rename_core_chk.sv
verif/rename_core_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f list.f --top-module rename_core_tb -o rename_core_sim
./obj_dir/rename_core_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "Verification passed" sim.log; then
  exit 0
else
  exit 1
fi
